// File: gf_pkg.sv
`default_nettype none

package gf_pkg;

	localparam int gf_m = 5;                  // field width in bits.
	localparam int gf_n = (1 << gf_m) - 1;    // multiplicative group order.

	typedef logic [gf_m-1:0] gf_elem_t;

	// x^5 + x^2 + 1 with the x^5 term dropped.
	localparam gf_elem_t gf_prim_poly = 5'b00101;

	// multiply an element by alpha, one shift and a conditional reduce.
	function automatic gf_elem_t gf_mul_alpha(gf_elem_t a);
		gf_elem_t r;
		r = gf_elem_t'(a << 1);
		if (a[gf_m-1])
			r = r ^ gf_prim_poly;
		return r;
	endfunction

	// alpha^e for any integer e, negative exponents wrap mod 31.
	function automatic gf_elem_t gf_alpha_pow(int e);
		int r;
		gf_elem_t p;
		r = e % gf_n;
		if (r < 0)
			r += gf_n;
		p = gf_elem_t'(1);
		for (int i = 0; i < gf_n; i++) begin
			if (i < r)
				p = gf_mul_alpha(p);
		end
		return p;
	endfunction

	// squaring is linear over GF(2); bit i of a maps to alpha^(2i).
	function automatic gf_elem_t gf_square(gf_elem_t a);
		gf_elem_t r;
		r = '0;
		for (int i = 0; i < gf_m; i++) begin
			if (a[i])
				r = r ^ gf_alpha_pow(2 * i);
		end
		return r;
	endfunction

endpackage

`default_nettype wire

// File: bch_pkg.sv
`default_nettype none

package bch_pkg;

	import gf_pkg::*;

	// shortened BCH(31,16), t = 3, cut to 28 bits.
	localparam int code_len = 28;
	localparam int beat_bits = 4;                     // bits taken per beat.
	localparam int beat_count = code_len / beat_bits; // 7 beats per word.
	localparam int syn_count = 6;                     // S1 to S6.

	typedef logic [$clog2(beat_count)-1:0] beat_cnt_t;

	// the first member sits in the top bits.
	typedef struct packed {
		gf_elem_t s6;
		gf_elem_t s5;
		gf_elem_t s4;
		gf_elem_t s3;
		gf_elem_t s2;
		gf_elem_t s1;
	} syn_vec_t;

	typedef enum logic [1:0] {
		st_idle,    // waiting for a start beat.
		st_collect, // beats of a word arriving.
		st_flush    // last term still in the lane register.
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: gf_mult.sv
`timescale 1ns/10ps
`default_nettype none

// standard basis multiplier over GF(2^5).
module gf_mult import gf_pkg::*; (
	input gf_elem_t a,
	input gf_elem_t b,
	output gf_elem_t p
);

	logic [2*gf_m-2:0] prod; // carry-less product, degree up to 8.

	always_comb begin
		prod = '0;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				prod = prod ^ ((2*gf_m-1)'(a) << i);
		end
		// fold the high terms down, top bit first.
		for (int k = 2*gf_m-2; k >= gf_m; k--) begin
			if (prod[k])
				prod[k-gf_m +: gf_m] = prod[k-gf_m +: gf_m] ^ gf_prim_poly;
		end
	end

	assign p = prod[gf_m-1:0]; // only the reduced part is kept.

endmodule

`default_nettype wire

// File: syndrome_lane.sv
`timescale 1ns/10ps
`default_nettype none

// one odd syndrome S_j = r(alpha^j), evaluated one beat per clock.
// bits arrive MSB first, so the power register steps downward.
module syndrome_lane import gf_pkg::*; import bch_pkg::*; #(
	parameter int syn_idx = 1
) (
	input logic clk,
	input logic reset,
	input logic start,
	input logic ce,
	input logic flush,
	input logic [beat_bits-1:0] data,
	output gf_elem_t syn
);

	// lowest bit of the first beat has exponent 24.
	localparam gf_elem_t pow_init = gf_alpha_pow(syn_idx * (code_len - beat_bits));
	localparam gf_elem_t pow_step = gf_alpha_pow(-syn_idx * beat_bits);

	gf_elem_t pow_q;                     // alpha^(j*e) for the next beat.
	gf_elem_t pow_cur;
	gf_elem_t pow_next;
	gf_elem_t [beat_bits-1:0] weighted;  // pow_cur * alpha^(j*b).
	gf_elem_t term_sum;
	gf_elem_t term_q;
	logic term_tag;                      // term_q holds an accepted beat.
	logic term_first;                    // term_q came from a start beat.
	gf_elem_t acc_q;

	// a start beat uses the initial power straight away.
	assign pow_cur = start ? pow_init : pow_q;

	for (genvar b = 0; b < beat_bits; b++) begin : g_weight
		localparam gf_elem_t bit_w = gf_alpha_pow(syn_idx * b);

		gf_mult u_weight (
			.a(pow_cur),
			.b(bit_w),
			.p(weighted[b])
		);
	end

	gf_mult u_step (
		.a(pow_cur),
		.b(pow_step),
		.p(pow_next)
	);

	always_comb begin
		term_sum = '0;
		for (int b = 0; b < beat_bits; b++) begin
			if (data[b])
				term_sum = term_sum ^ weighted[b];
		end
	end

	always_ff @(posedge clk) begin
		if (ce) begin
			pow_q <= pow_next;   // move down by one beat.
			term_q <= term_sum;
		end
	end

	// tag rides along with term_q, so gaps do not hold the term back.
	always_ff @(posedge clk) begin
		if (reset) begin
			term_tag <= 1'b0;
			term_first <= 1'b0;
		end else begin
			term_tag <= ce;
			term_first <= ce & start;
		end
	end

	always_ff @(posedge clk) begin
		if (term_tag) begin
			if (term_first)
				acc_q <= term_q;       // new word, drop the old sum.
			else
				acc_q <= acc_q ^ term_q;
		end
	end

	// during flush the final term is added in ahead of the accumulator.
	assign syn = flush ? (acc_q ^ term_q) : acc_q;

endmodule

`default_nettype wire

// File: syndrome_bank.sv
`timescale 1ns/10ps
`default_nettype none

// odd syndromes from three lanes, even ones by squaring.
module syndrome_bank import gf_pkg::*; import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic ce,
	input logic flush,
	input logic [beat_bits-1:0] data,
	output syn_vec_t syndromes
);

	gf_elem_t s1;
	gf_elem_t s2;
	gf_elem_t s3;
	gf_elem_t s5;

	syndrome_lane #(
		.syn_idx(1)
	) u_lane_s1 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.ce(ce),
		.flush(flush),
		.data(data),
		.syn(s1)
	);

	syndrome_lane #(
		.syn_idx(3)
	) u_lane_s3 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.ce(ce),
		.flush(flush),
		.data(data),
		.syn(s3)
	);

	syndrome_lane #(
		.syn_idx(5)
	) u_lane_s5 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.ce(ce),
		.flush(flush),
		.data(data),
		.syn(s5)
	);

	// S2j = Sj^2 holds for binary codes.
	assign s2 = gf_square(s1);

	always_comb begin
		syndromes.s1 = s1;
		syndromes.s2 = s2;
		syndromes.s3 = s3;
		syndromes.s4 = gf_square(s2); // S4 = S2^2.
		syndromes.s5 = s5;
		syndromes.s6 = gf_square(s3); // S6 = S3^2.
	end

endmodule

`default_nettype wire

// File: syndrome_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// counts beats of a codeword and sequences flush and done.
module syndrome_ctrl import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic valid,
	output logic lane_start,
	output logic lane_ce,
	output logic lane_flush,
	output logic done
);

	ctrl_state_e state_q;
	beat_cnt_t cnt_q;    // beats taken so far in this word.
	logic first_beat;
	logic more_beat;

	// a start beat is taken in any state and abandons a word in progress.
	assign first_beat = valid & start;
	// beats without start count only while a word is open.
	assign more_beat = valid & ~start & (state_q == st_collect);

	assign lane_start = first_beat;
	assign lane_ce = first_beat | more_beat;
	assign lane_flush = (state_q == st_flush);

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= st_idle;
			cnt_q <= '0;
			done <= 1'b0;
		end else begin
			done <= lane_flush; // one cycle after the flush cycle.
			if (first_beat) begin
				state_q <= st_collect;
				cnt_q <= beat_cnt_t'(1);
			end else if (more_beat) begin
				if (cnt_q == beat_cnt_t'(beat_count - 1)) begin
					state_q <= st_flush; // seventh beat just taken.
					cnt_q <= '0;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end else if (state_q == st_flush) begin
				state_q <= st_idle;
			end
		end
	end

endmodule

`default_nettype wire

// File: bch_syndrome_top.sv
`timescale 1ns/10ps
`default_nettype none

// syndrome stage of the BCH(28,13) decoder.
module bch_syndrome_top import gf_pkg::*; import bch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input logic valid,
	input logic [beat_bits-1:0] data,
	output syn_vec_t syndromes,
	output logic done,
	output logic error
);

	logic lane_start;
	logic lane_ce;
	logic lane_flush;
	syn_vec_t bank_syn;
	logic [syn_count-1:0] syn_nz; // one flag per syndrome.

	syndrome_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.start(start),
		.valid(valid),
		.lane_start(lane_start),
		.lane_ce(lane_ce),
		.lane_flush(lane_flush),
		.done(done)
	);

	syndrome_bank u_bank (
		.clk(clk),
		.reset(reset),
		.start(lane_start),
		.ce(lane_ce),
		.flush(lane_flush),
		.data(data),
		.syndromes(bank_syn)
	);

	always_comb begin
		for (int i = 0; i < syn_count; i++)
			syn_nz[i] = |bank_syn[i*gf_m +: gf_m];
	end

	// captured on the flush cycle so they appear together with done.
	always_ff @(posedge clk) begin
		if (reset) begin
			syndromes <= '0;
			error <= 1'b0;
		end else if (lane_flush) begin
			syndromes <= bank_syn;
			error <= |syn_nz;
		end
	end

endmodule

`default_nettype wire

// File: tb_bch_syndrome.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bch_syndrome import gf_pkg::*; import bch_pkg::*; ();

	localparam logic [15:0] gen_poly = 16'h8faf;    // m1 * m3 * m5 for x^5 + x^2 + 1.
	localparam logic [4:0] field_poly = 5'b00101;
	localparam int max_cycles = 20 * 12 * 10;       // 20 words, 12 cycles each, margin 10x.

	logic clk;
	logic reset;
	logic start;
	logic valid;
	logic [beat_bits-1:0] data;
	syn_vec_t syndromes;
	logic done;
	logic error;

	syn_vec_t exp_syn;
	logic exp_err;
	logic last_beat;        // high while the seventh beat is on the bus.
	logic [31:0] lfsr_q;
	int words_sent;
	int words_done;
	int cycles;

	bch_syndrome_top dut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.valid(valid),
		.data(data),
		.syndromes(syndromes),
		.done(done),
		.error(error)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1.
	endfunction

	function automatic gf_elem_t fmul(gf_elem_t a, gf_elem_t b);
		gf_elem_t r;
		gf_elem_t x;
		r = '0;
		x = a;
		for (int i = 0; i < 5; i++) begin
			if (b[i])
				r = r ^ x;
			x = x[4] ? ({x[3:0], 1'b0} ^ field_poly) : {x[3:0], 1'b0};
		end
		return r;
	endfunction

	// r(alpha^j) by Horner, highest coefficient first.
	function automatic gf_elem_t eval_at(logic [code_len-1:0] cw, int j);
		gf_elem_t beta;
		gf_elem_t acc;
		beta = 5'd1;
		acc = '0;
		for (int i = 0; i < j; i++)
			beta = fmul(beta, 5'b00010);
		for (int i = code_len - 1; i >= 0; i--)
			acc = fmul(acc, beta) ^ {4'b0, cw[i]};
		return acc;
	endfunction

	function automatic syn_vec_t syn_model(logic [code_len-1:0] cw);
		syn_vec_t s;
		s.s1 = eval_at(cw, 1);
		s.s2 = eval_at(cw, 2);
		s.s3 = eval_at(cw, 3);
		s.s4 = eval_at(cw, 4);
		s.s5 = eval_at(cw, 5);
		s.s6 = eval_at(cw, 6);
		return s;
	endfunction

	// message times generator, carry-less.
	function automatic logic [code_len-1:0] encode(logic [12:0] msg);
		logic [code_len-1:0] cw;
		cw = '0;
		for (int i = 0; i < 13; i++) begin
			if (msg[i])
				cw = cw ^ (code_len'(gen_poly) << i);
		end
		return cw;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	task automatic fail_msg(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("ERR %s expected %h got %h", name, exp, got);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			start = 1'b0;
			valid = 1'b0;
			data = '0;
			last_beat = 1'b0;
		end
	endtask

	task automatic drive_beat(input logic st, input logic [beat_bits-1:0] d);
		@(negedge clk);
		start = st;
		valid = 1'b1;
		data = d;
		last_beat = 1'b0;
	endtask

	// MSB first, random gaps of up to gap_max cycles between beats.
	task automatic send_beats(input logic [code_len-1:0] cw, input int nbeats, input int gap_max);
		logic [31:0] g;
		for (int k = 0; k < nbeats; k++) begin
			if (k > 0 && gap_max > 0) begin
				take_bits(2, g);
				idle_cycles(g % (gap_max + 1));
			end
			drive_beat(k == 0, cw[code_len-1-beat_bits*k -: beat_bits]);
			if (k == beat_count - 1) begin
				last_beat = 1'b1;
				words_sent++;
			end
		end
	endtask

	task automatic add_flips(inout logic [code_len-1:0] cw);
		logic [31:0] v;
		logic [code_len-1:0] mask;
		int n;
		int cnt;
		int pos;
		mask = '0;
		cnt = 0;
		take_bits(2, v);
		n = (v[1:0] == 2'd0) ? 1 : int'(v[1:0]);
		while (cnt < n) begin
			take_bits(5, v);
			pos = v[4:0] % code_len;
			if (!mask[pos]) begin
				mask[pos] = 1'b1;
				cnt++;
			end
		end
		cw = cw ^ mask;
		if (syn_model(cw) == '0)
			fail_msg("a corrupted codeword has all-zero model syndromes");
	endtask

	task automatic check_word(input logic [code_len-1:0] cw, input int gap_max);
		exp_syn = syn_model(cw);
		exp_err = (exp_syn != '0);
		send_beats(cw, beat_count, gap_max);
		idle_cycles(1);
		do
			@(negedge clk);
		while (!done);
		@(negedge clk); // keep the expectation until done has dropped.
	endtask

	always @(posedge clk) begin
		if (reset)
			words_done <= 0;
		else if (done)
			words_done <= words_done + 1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("run did not finish within %0d cycles", max_cycles);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	end

	a_syn: assert property (@(posedge clk) disable iff (reset) done |-> syndromes == exp_syn)
		else fail_value("syndromes", $sampled(exp_syn), $sampled(syndromes));

	a_err: assert property (@(posedge clk) disable iff (reset) done |-> error == exp_err)
		else fail_value("error", $sampled(exp_err), $sampled(error));

	a_err_any: assert property (@(posedge clk) disable iff (reset) error == (syndromes != '0))
		else fail_value("error", $sampled(syndromes != '0), $sampled(error));

	a_even: assert property (@(posedge clk) disable iff (reset) done |->
		{syndromes.s6, syndromes.s4, syndromes.s2} == {fmul(syndromes.s3, syndromes.s3),
		fmul(syndromes.s2, syndromes.s2), fmul(syndromes.s1, syndromes.s1)})
		else fail_value("syndromes.s6_s4_s2", {$sampled(fmul(syndromes.s3, syndromes.s3)),
			$sampled(fmul(syndromes.s2, syndromes.s2)), $sampled(fmul(syndromes.s1, syndromes.s1))},
			{$sampled(syndromes.s6), $sampled(syndromes.s4), $sampled(syndromes.s2)});

	// done comes one cycle after the edge that follows the last beat.
	a_done_late: assert property (@(posedge clk) disable iff (reset) last_beat |-> ##2 done)
		else fail_msg("done did not follow the last beat of a codeword in time");

	a_done_cause: assert property (@(posedge clk) disable iff (reset) done |-> $past(last_beat, 2))
		else fail_msg("done was raised without a completed codeword");

	initial begin
		logic [31:0] v;
		logic [code_len-1:0] cw;
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		valid = 1'b0;
		data = '0;
		last_beat = 1'b0;
		exp_syn = '0;
		exp_err = 1'b0;
		lfsr_q = 32'habac;
		words_sent = 0;
		cycles = 0;
		for (int j = 1; j <= 5; j += 2) begin
			if (eval_at(code_len'(gen_poly), j) != '0)
				fail_msg($sformatf("generator polynomial has no root at alpha^%0d", j));
		end
		repeat (10) @(negedge clk);
		reset = 1'b0;
		idle_cycles(2);
		check_word('0, 0); // all-zero codeword.
		repeat (5) begin
			take_bits(13, v);
			check_word(encode(v[12:0]), 0);
		end
		repeat (6) begin
			take_bits(13, v);
			cw = encode(v[12:0]);
			add_flips(cw);
			check_word(cw, 0);
		end
		// valid-low gaps, clean words then corrupted ones.
		for (int i = 0; i < 6; i++) begin
			take_bits(13, v);
			cw = encode(v[12:0]);
			if (i >= 3)
				add_flips(cw);
			check_word(cw, 3);
		end
		take_bits(13, v);
		send_beats(encode(v[12:0]), 4, 0); // abandoned by the next start.
		take_bits(13, v);
		cw = encode(v[12:0]);
		add_flips(cw);
		check_word(cw, 0);
		// a full word's worth, enough to reach a flush if idle beats were counted.
		repeat (beat_count) begin
			take_bits(beat_bits, v);
			drive_beat(1'b0, v[beat_bits-1:0]); // no start while idle.
		end
		idle_cycles(6);
		take_bits(13, v);
		check_word(encode(v[12:0]), 1);
		idle_cycles(4);
		if (words_done == words_sent && words_sent == 20) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			$display("saw %0d done pulses for %0d codewords", words_done, words_sent);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

// File: bch_syndrome_top.f
gf_pkg.sv
bch_pkg.sv
gf_mult.sv
syndrome_lane.sv
syndrome_bank.sv
syndrome_ctrl.sv
bch_syndrome_top.sv
tb_bch_syndrome.sv

// File: Bender.yml
package:
  name: bch_syndrome

dependencies: {}

sources:
  # packages first, then the design in dependency order.
  - files:
      - gf_pkg.sv
      - bch_pkg.sv
      - gf_mult.sv
      - syndrome_lane.sv
      - syndrome_bank.sv
      - syndrome_ctrl.sv
      - bch_syndrome_top.sv

  # testbench, only for simulation.
  - target: test
    files:
      - tb_bch_syndrome.sv
